/* rtl/alu.sv */
`include "cpu_config.svh"
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    input  cc_t     cc_in,
    output word_t   result,
    output cc_t     cc_out
);

    localparam int SHW = $clog2(`CPU_XLEN);     // shift amount bits

    logic              arith;
    logic              cin;
    word_t             b_eff;        // b, or ~b on subtract
    logic [`CPU_XLEN:0] sum;         // extra bit is carry out

    always_comb begin
        arith = op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC};
        b_eff = (op inside {ALU_SUB, ALU_SBC}) ? ~b : b;
        case (op)
            ALU_ADC, ALU_SBC: cin = cc_in.c;   // sbc: a - b - !c
            ALU_SUB:          cin = 1'b1;
            default:          cin = 1'b0;
        endcase
        sum = {1'b0, a} + {1'b0, b_eff} + {{`CPU_XLEN{1'b0}}, cin};
    end

    always_comb begin
        case (op)
            ALU_ADD, ALU_ADC,
            ALU_SUB, ALU_SBC: result = sum[`CPU_XLEN-1:0];
            ALU_AND:          result = a & b;
            ALU_OR:           result = a | b;
            ALU_XOR:          result = a ^ b;
            ALU_MOV:          result = b;
            ALU_NOT:          result = ~b;
            ALU_LSL:          result = a << b[SHW-1:0];
            ALU_LSR:          result = a >> b[SHW-1:0];
            ALU_ASR:          result = $unsigned($signed(a) >>> b[SHW-1:0]);
            default:          result = '0;     // 12..15 not decodable
        endcase
    end

    always_comb begin
        cc_out   = cc_in;
        cc_out.n = result[`CPU_XLEN-1];
        cc_out.z = result == '0;
        if (arith) begin
            cc_out.c = sum[`CPU_XLEN];
            // same-sign inputs, different-sign output
            cc_out.v = (a[`CPU_XLEN-1] == b_eff[`CPU_XLEN-1]) &&
                       (sum[`CPU_XLEN-1] != a[`CPU_XLEN-1]);
        end
    end

endmodule

`default_nettype wire

/* rtl/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and address width
`define CPU_XLEN 16

// general registers r0..r7
`define CPU_NREGS 8

// pc held here during reset, so first fetch is word 0
`define CPU_RESET_PC 16'hffff

// memory opcodes inside the 0110? group
`define CPU_OP_LOAD 5'b01100
`define CPU_OP_STORE 5'b01101

// branch cond that selects register or long branch
`define CPU_CC_LONG 4'b1111

`endif

/* rtl/cpu_pkg.sv */
`include "cpu_config.svh"
`default_nettype none

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

    // alu / load / store layout
    typedef struct packed {
        logic [4:0] op;          // 00??? and 010?? alu, 0110? mem
        reg_idx_t   rd;
        reg_idx_t   ra;
        logic [1:0] mode;        // 0? imm4, 10 reg, 11 zero or next word
        reg_idx_t   rb;          // bit 2 picks next word when mode is 11
    } alu_fmt_t;

    // branch layout
    typedef struct packed {
        logic [1:0] br_class;    // 10 for every branch
        logic [3:0] cond;
        logic [9:0] offset10;    // low 3 bits double as target reg
    } br_fmt_t;

    // one instruction word, two views
    typedef union packed {
        alu_fmt_t alu;
        br_fmt_t  br;
    } instr_u;

    typedef struct packed {
        logic n;
        logic z;
        logic c;                 // carry, or no-borrow on subtract
        logic v;
    } cc_t;

    // low four opcode bits map straight onto this
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_ADC = 4'd1,
        ALU_SUB = 4'd2,
        ALU_SBC = 4'd3,
        ALU_AND = 4'd4,
        ALU_OR  = 4'd5,
        ALU_XOR = 4'd6,
        ALU_MOV = 4'd7,
        ALU_NOT = 4'd8,
        ALU_LSL = 4'd9,
        ALU_LSR = 4'd10,
        ALU_ASR = 4'd11
    } alu_op_e;

    typedef enum logic [1:0] {
        DS_DECODE,
        DS_IMM_WAIT,             // grabbing the word after the instruction
        DS_LOAD_WAIT,            // read data arrives this cycle
        DS_BRANCH_DELAY          // drop the word already fetched
    } dstate_e;

endpackage

`default_nettype wire

/* rtl/cpu_top.sv */
`include "cpu_config.svh"
`default_nettype none

module cpu_top (
    input  logic                 clk,
    input  logic                 rst,
    output logic [`CPU_XLEN-1:0] iaddr,
    input  logic [`CPU_XLEN-1:0] idata,
    output logic [`CPU_XLEN-1:0] raddr,
    output logic                 re,
    input  logic [`CPU_XLEN-1:0] rdata,
    output logic [`CPU_XLEN-1:0] waddr,
    output logic [`CPU_XLEN-1:0] wdata,
    output logic                 we
);

    // fetch <-> control
    logic                           take_branch;
    logic                           stall;
    logic [`CPU_XLEN-1:0]           branch_target;
    logic [`CPU_XLEN-1:0]           pc;

    // register file
    logic [$clog2(`CPU_NREGS)-1:0]  rd_addr;
    logic [$clog2(`CPU_NREGS)-1:0]  ra_addr;
    logic [$clog2(`CPU_NREGS)-1:0]  rb_addr;
    logic [`CPU_XLEN-1:0]           ra_data;
    logic [`CPU_XLEN-1:0]           rb_data;
    logic [`CPU_XLEN-1:0]           rd_data;
    logic                           wr_en;
    logic [`CPU_XLEN-1:0]           wr_data;

    // alu
    cpu_pkg::alu_op_e               alu_op;
    logic [`CPU_XLEN-1:0]           op_a;
    logic [`CPU_XLEN-1:0]           op_b;
    logic [`CPU_XLEN-1:0]           alu_result;
    cpu_pkg::cc_t                   alu_cc;
    cpu_pkg::cc_t                   cc;           // flags fed back to the alu

    fetch_unit u_fetch (
        .clk           (clk),
        .rst           (rst),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .stall         (stall),
        .pc            (pc),
        .iaddr         (iaddr)
    );

    decode_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .idata         (idata),
        .pc            (pc),
        .rd_addr       (rd_addr),
        .ra_addr       (ra_addr),
        .rb_addr       (rb_addr),
        .ra_data       (ra_data),
        .rb_data       (rb_data),
        .rd_data       (rd_data),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .alu_op        (alu_op),
        .op_a          (op_a),
        .op_b          (op_b),
        .alu_result    (alu_result),
        .alu_cc        (alu_cc),
        .cc            (cc),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .stall         (stall),
        .raddr         (raddr),
        .re            (re),
        .rdata         (rdata),
        .waddr         (waddr),
        .wdata         (wdata),
        .we            (we)
    );

    // writes always land in rd
    reg_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .ra_addr (ra_addr),
        .rb_addr (rb_addr),
        .rd_addr (rd_addr),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (rd_addr),
        .wr_data (wr_data)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (op_a),
        .b      (op_b),
        .cc_in  (cc),
        .result (alu_result),
        .cc_out (alu_cc)
    );

endmodule

`default_nettype wire

/* rtl/decode_ctrl.sv */
`include "cpu_config.svh"
`default_nettype none

module decode_ctrl import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    idata,
    input  word_t    pc,             // one past the word in ir
    output reg_idx_t rd_addr,
    output reg_idx_t ra_addr,
    output reg_idx_t rb_addr,
    input  word_t    ra_data,
    input  word_t    rb_data,
    input  word_t    rd_data,
    output logic     wr_en,
    output word_t    wr_data,
    output alu_op_e  alu_op,
    output word_t    op_a,
    output word_t    op_b,
    input  word_t    alu_result,
    input  cc_t      alu_cc,
    output cc_t      cc,             // flags register
    output logic     take_branch,
    output word_t    branch_target,
    output logic     stall,
    output word_t    raddr,
    output logic     re,
    input  word_t    rdata,
    output word_t    waddr,
    output word_t    wdata,
    output logic     we
);

    instr_u  ir;
    instr_u  ir_next;
    word_t   imm_q;                  // word that followed the instruction
    logic    imm_load;
    cc_t     cc_next;
    dstate_e state;
    dstate_e state_next;
    logic    boot;                   // first cycle out of reset

    word_t   imm4_sx;
    word_t   off10_sx;
    logic    is_branch;
    logic    is_alu;
    logic    is_mem;
    logic    need_imm;
    logic    cond_true;

    assign rd_addr  = ir.alu.rd;
    assign ra_addr  = ir.alu.ra;
    assign rb_addr  = ir.alu.rb;     // same bits as the register-branch target
    assign imm4_sx  = {{(`CPU_XLEN-4){ir[3]}}, ir[3:0]};
    assign off10_sx = {{(`CPU_XLEN-10){ir.br.offset10[9]}}, ir.br.offset10};

    assign is_branch = ir.br.br_class == 2'b10;
    assign is_alu    = ir.alu.op[4:3] == 2'b00 || ir.alu.op[4:2] == 3'b010;
    assign is_mem    = ir.alu.op == `CPU_OP_LOAD || ir.alu.op == `CPU_OP_STORE;
    assign need_imm  = ir.alu.mode == 2'b11 && ir[2];

    // address is always ra + operand b through the alu
    assign op_a  = ra_data;
    assign raddr = alu_result;
    assign waddr = alu_result;
    assign wdata = rd_data;

    // second operand
    always_comb begin
        case (ir.alu.mode)
            2'b10:   op_b = rb_data;
            2'b11:   op_b = ir[2] ? imm_q : '0;   // long word or zero
            default: op_b = imm4_sx;
        endcase
    end

    always_comb begin
        case (ir.br.cond)
            4'h0:    cond_true = cc.z;                      // eq
            4'h1:    cond_true = !cc.z;                     // ne
            4'h2:    cond_true = cc.c;                      // cs
            4'h3:    cond_true = !cc.c;                     // cc
            4'h4:    cond_true = cc.n;                      // mi
            4'h5:    cond_true = !cc.n;                     // pl
            4'h6:    cond_true = cc.v;                      // vs
            4'h7:    cond_true = !cc.v;                     // vc
            4'h8:    cond_true = cc.c && !cc.z;             // hi
            4'h9:    cond_true = !cc.c || cc.z;             // ls
            4'ha:    cond_true = cc.n == cc.v;              // ge
            4'hb:    cond_true = cc.n != cc.v;              // lt
            4'hc:    cond_true = !cc.z && (cc.n == cc.v);   // gt
            4'hd:    cond_true = cc.z || (cc.n != cc.v);    // le
            4'he:    cond_true = 1'b1;                      // al
            default: cond_true = 1'b0;                      // long form, handled apart
        endcase
    end

    always_comb begin
        state_next    = state;
        ir_next       = idata;       // normally take the fetched word
        imm_load      = 1'b0;
        cc_next       = cc;
        alu_op        = ALU_ADD;
        take_branch   = 1'b0;
        branch_target = pc + off10_sx;
        stall         = 1'b0;
        wr_en         = 1'b0;
        wr_data       = alu_result;
        re            = 1'b0;
        we            = 1'b0;

        if (state == DS_BRANCH_DELAY) begin
            // two dead cycles after reset, one after a branch
            state_next = boot ? DS_BRANCH_DELAY : DS_DECODE;
        end else if (is_branch) begin
            if (ir.br.cond != `CPU_CC_LONG) begin
                take_branch = cond_true;
            end else if (ir[2:0] != 3'd0) begin
                take_branch   = 1'b1;
                branch_target = rb_data;
            end else if (state == DS_DECODE) begin
                state_next = DS_IMM_WAIT;     // offset is the next word
                ir_next    = ir;
                imm_load   = 1'b1;
            end else begin
                take_branch   = 1'b1;
                branch_target = pc + imm_q;
            end
            if (take_branch) begin
                state_next = DS_BRANCH_DELAY;
            end
        end else if (need_imm && state == DS_DECODE && (is_alu || is_mem)) begin
            state_next = DS_IMM_WAIT;
            ir_next    = ir;
            imm_load   = 1'b1;
        end else if (is_alu) begin
            alu_op     = alu_op_e'(ir.alu.op[3:0]);
            state_next = DS_DECODE;
            wr_en      = 1'b1;
            cc_next    = alu_cc;
        end else if (ir.alu.op == `CPU_OP_LOAD) begin
            if (state == DS_LOAD_WAIT) begin
                state_next = DS_DECODE;
                wr_en      = 1'b1;
                wr_data    = rdata;
            end else begin
                re         = 1'b1;
                stall      = 1'b1;           // hold fetch, next word comes again
                ir_next    = ir;
                state_next = DS_LOAD_WAIT;
            end
        end else if (ir.alu.op == `CPU_OP_STORE) begin
            we         = 1'b1;
            state_next = DS_DECODE;
        end
        // push/pop and 11??? fall through as no-ops
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DS_BRANCH_DELAY;
            boot  <= 1'b1;
            ir    <= '0;
            cc    <= '0;
        end else begin
            state <= state_next;
            boot  <= 1'b0;
            ir    <= ir_next;
            cc    <= cc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (imm_load) begin
            imm_q <= idata;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`include "cpu_config.svh"
`default_nettype none

module fetch_unit import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  take_branch,
    input  word_t branch_target,
    input  logic  stall,
    output word_t pc,            // address of the word being fetched now
    output word_t iaddr
);

    word_t pc_next;

    always_comb begin
        if (stall) begin
            pc_next = pc;                   // refetch same word
        end else if (take_branch) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + word_t'(1);      // sequential
        end
    end

    // memory sees the new address in the same cycle
    assign iaddr = pc_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CPU_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`include "cpu_config.svh"
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t ra_addr,
    input  reg_idx_t rb_addr,
    input  reg_idx_t rd_addr,
    output word_t    ra_data,
    output word_t    rb_data,
    output word_t    rd_data,        // store data
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data
);

    word_t regs [`CPU_NREGS];

    // async reads, no bypass of the pending write
    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];
    assign rd_data = regs[rd_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_cpu -Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* sim.f */
+incdir+rtl
+incdir+tests
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/fetch_unit.sv
rtl/decode_ctrl.sv
rtl/cpu_top.sv
tests/tb_cpu.sv

/* tests/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// opcode and condition numbers as the encoder helpers take them
localparam int OP_ADD = 0;
localparam int OP_SUB = 2;
localparam int OP_MOV = 7;
localparam int OP_XOR = 6;
localparam int OP_LSR = 10;
localparam int OP_LD  = 12;
localparam int OP_ST  = 13;
localparam int CC_AL  = 14;

int pp;                              // next free word of the program image

logic [15:0] exp_addr [$];           // store addresses the reference predicts
logic [15:0] exp_data [$];
logic [15:0] exp_raddr [$];          // load addresses in program order

// encoders for the alu and memory forms
function automatic logic [15:0] imm_form(input int op, input int rd, input int ra, input int imm);
    return {5'(op), 3'(rd), 3'(ra), 1'b0, 4'(imm)};
endfunction

function automatic logic [15:0] reg_form(input int op, input int rd, input int ra, input int rb);
    return {5'(op), 3'(rd), 3'(ra), 2'b10, 3'(rb)};
endfunction

function automatic logic [15:0] zero_form(input int op, input int rd, input int ra);
    return {5'(op), 3'(rd), 3'(ra), 2'b11, 3'b000};
endfunction

function automatic logic [15:0] long_form(input int op, input int rd, input int ra);
    return {5'(op), 3'(rd), 3'(ra), 2'b11, 3'b100};   // operand is the next word
endfunction

function automatic logic [15:0] branch_word(input int cond, input int off);
    return {2'b10, 4'(cond), 10'(off)};
endfunction

function automatic logic [15:0] reg_branch_word(input int rb);
    return {2'b10, 4'hf, 7'd0, 3'(rb)};
endfunction

function automatic logic [15:0] long_branch_word();
    return {2'b10, 4'hf, 10'd0};
endfunction

// five flag patterns that send every condition except al both ways
function automatic logic [15:0] flag_setup(input int s);
    case (s)
        0:       return reg_form(OP_SUB, 0, 1, 1);   // z c
        1:       return imm_form(OP_ADD, 0, 2, 2);   // n v
        2:       return reg_form(OP_ADD, 0, 1, 1);   // c v
        3:       return imm_form(OP_SUB, 0, 2, 1);   // c only
        default: return imm_form(OP_SUB, 0, 3, 0);   // n c
    endcase
endfunction

task automatic emit_word(input logic [15:0] w);
    imem[pp] = w;
    pp++;
endtask

task automatic build_program();
    pp = 0;
    emit_word(long_form(OP_MOV, 7, 0));    // r7 store pointer
    emit_word(16'h0080);
    emit_word(long_form(OP_MOV, 1, 0));
    emit_word(16'h8123);
    emit_word(long_form(OP_MOV, 2, 0));
    emit_word(16'h7ffe);
    emit_word(imm_form(OP_MOV, 3, 0, -3));
    // each alu op in all four operand forms
    for (int k = 0; k < 12; k++) begin
        emit_word(imm_form(OP_SUB, 0, 2, 1));      // carry in set
        emit_word(imm_form(k, 4, 1, 5));
        emit_word(reg_form(k, 5, 2, 1));
        emit_word(long_form(k, 6, 3));
        emit_word(16'h1357 + 16'(k * 273));
        emit_word(zero_form(k, 0, 2));
        emit_word(imm_form(OP_ST, 4, 7, 0));
        emit_word(imm_form(OP_ST, 5, 7, 1));
        emit_word(imm_form(OP_ST, 6, 7, 2));
        emit_word(imm_form(OP_ST, 0, 7, 3));
        emit_word(imm_form(OP_ADD, 7, 7, 4));
    end
    // short branches over one store
    for (int s = 0; s < 5; s++) begin
        for (int cnd = 0; cnd < 15; cnd++) begin
            emit_word(imm_form(OP_ADD, 7, 7, 2));
            emit_word(flag_setup(s));
            emit_word(branch_word(cnd, 1));
            emit_word(imm_form(OP_ST, 1, 7, 0));   // only on fall-through
            emit_word(imm_form(OP_ST, 2, 7, 1));
        end
    end
    emit_word(long_form(OP_MOV, 6, 0));
    emit_word(16'(pp + 3));                         // register branch target
    emit_word(reg_branch_word(6));
    emit_word(imm_form(OP_ST, 1, 7, 0));
    emit_word(imm_form(OP_ST, 2, 7, 1));
    emit_word(long_branch_word());
    emit_word(16'h0002);                            // skip two words
    emit_word(imm_form(OP_ST, 1, 7, 2));
    emit_word(imm_form(OP_ST, 1, 7, 3));
    emit_word(imm_form(OP_ST, 3, 7, 4));
    emit_word(imm_form(OP_ADD, 7, 7, 5));
    // loads from the random area
    emit_word(long_form(OP_MOV, 1, 0));
    emit_word(16'h0040);
    emit_word(imm_form(OP_MOV, 3, 0, 5));
    emit_word(imm_form(OP_LD, 4, 1, 0));
    emit_word(imm_form(OP_ST, 4, 7, 0));           // loaded value used at once
    emit_word(imm_form(OP_LD, 5, 1, 3));
    emit_word(imm_form(OP_ADD, 5, 5, 7));
    emit_word(imm_form(OP_ST, 5, 7, 1));
    emit_word(reg_form(OP_LD, 6, 1, 3));
    emit_word(reg_form(OP_XOR, 6, 6, 4));
    emit_word(imm_form(OP_ST, 6, 7, 2));
    emit_word(long_form(OP_LD, 4, 1));
    emit_word(16'h0021);
    emit_word(imm_form(OP_ST, 4, 7, 3));
    emit_word(zero_form(OP_LD, 5, 1));
    emit_word(imm_form(OP_LSR, 5, 5, 1));
    emit_word(imm_form(OP_ST, 5, 7, 4));
    emit_word(imm_form(OP_LD, 0, 1, -8));
    emit_word(imm_form(OP_ST, 0, 7, 5));
    emit_word(branch_word(CC_AL, -1));              // halt
endtask

function automatic logic cond_holds(input logic [3:0] cond, input logic n, input logic z,
                                    input logic c, input logic v);
    case (cond)
        4'h0:    return z;
        4'h1:    return !z;
        4'h2:    return c;
        4'h3:    return !c;
        4'h4:    return n;
        4'h5:    return !n;
        4'h6:    return v;
        4'h7:    return !v;
        4'h8:    return c && !z;
        4'h9:    return !(c && !z);
        4'ha:    return n == v;
        4'hb:    return n != v;
        4'hc:    return !z && n == v;
        4'hd:    return z || n != v;
        default: return 1'b1;
    endcase
endfunction

// instruction-set model returning the executed count or -1
function automatic int iss_run(input int max_steps);
    logic [15:0] r [8];
    logic [15:0] dm [DMEM_WORDS];
    logic [15:0] pc;
    logic [15:0] nxt;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] ea;
    logic [15:0] target;
    logic [4:0]  op;
    logic        n;
    logic        z;
    logic        c;
    logic        v;
    logic        taken;
    logic        is_alu;
    int          steps;
    int          len;
    int          cin;
    int          ur;
    int          sr;
    for (int i = 0; i < 8; i++) begin
        r[i] = '0;
    end
    dm = dmem;
    pc = '0;
    {n, z, c, v} = 4'b0000;
    steps = 0;
    exp_addr.delete();
    exp_data.delete();
    exp_raddr.delete();
    while (steps < max_steps) begin
        w = imem[pc[9:0]];
        nxt = pc + 16'd1;
        steps++;
        if (w[15:14] == 2'b10) begin
            taken = 1'b1;
            if (w[13:10] != 4'hf) begin
                taken = cond_holds(w[13:10], n, z, c, v);
                target = nxt + {{6{w[9]}}, w[9:0]};
            end else if (w[2:0] != 3'd0) begin
                target = r[w[2:0]];
            end else begin
                target = pc + 16'd2 + imem[nxt[9:0]];   // offset from next word
            end
            if (!taken) begin
                pc = nxt;
            end else if (target == pc) begin
                return steps;                          // branch to self ends it
            end else begin
                pc = target;
            end
        end else begin
            op = w[15:11];
            is_alu = op[4:3] == 2'b00 || op[4:2] == 3'b010;
            len = 1;
            a = r[w[7:5]];
            case (w[4:3])
                2'b10:   b = r[w[2:0]];
                2'b11:   b = w[2] ? imem[nxt[9:0]] : 16'd0;
                default: b = {{12{w[3]}}, w[3:0]};
            endcase
            if (w[4:3] == 2'b11 && w[2] && (is_alu || op == 5'(OP_LD) || op == 5'(OP_ST))) begin
                len = 2;
            end
            ea = a + b;
            if (is_alu) begin
                case (op[3:0])
                    4'd0, 4'd1: begin
                        cin = (op[0] && c) ? 1 : 0;
                        ur = int'(a) + int'(b) + cin;
                        sr = int'($signed(a)) + int'($signed(b)) + cin;
                        c = ur > 65535;
                        v = sr > 32767 || sr < -32768;
                        res = 16'(ur);
                    end
                    4'd2, 4'd3: begin
                        cin = (op[0] && !c) ? 1 : 0;          // borrow in
                        ur = int'(a) - int'(b) - cin;
                        sr = int'($signed(a)) - int'($signed(b)) - cin;
                        c = ur >= 0;
                        v = sr > 32767 || sr < -32768;
                        res = 16'(ur);
                    end
                    4'd4:    res = a & b;
                    4'd5:    res = a | b;
                    4'd6:    res = a ^ b;
                    4'd7:    res = b;
                    4'd8:    res = ~b;
                    4'd9:    res = a << b[3:0];
                    4'd10:   res = a >> b[3:0];
                    default: res = $signed(a) >>> b[3:0];
                endcase
                n = res[15];
                z = res == 16'd0;
                r[w[10:8]] = res;
            end else if (op == 5'(OP_LD)) begin
                exp_raddr.push_back(ea);
                r[w[10:8]] = dm[ea[9:0]];
            end else if (op == 5'(OP_ST)) begin
                exp_addr.push_back(ea);
                exp_data.push_back(r[w[10:8]]);
                dm[ea[9:0]] = r[w[10:8]];
            end
            pc = pc + 16'(len);
        end
    end
    return -1;
endfunction

`endif

/* tests/tb_cpu.sv */
`default_nettype none

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMEM_WORDS = 1024;
    localparam int DMEM_WORDS = 1024;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [15:0] iaddr;
    logic [15:0] idata = '0;
    logic [15:0] raddr;
    logic        re;
    logic [15:0] rdata = '0;
    logic [15:0] waddr;
    logic [15:0] wdata;
    logic        we;

    logic [15:0] imem [IMEM_WORDS];
    logic [15:0] dmem [DMEM_WORDS];
    logic [15:0] iaddr_q = '0;       // address seen at the last rising edge
    logic [15:0] raddr_q = '0;
    logic        re_q = 1'b0;
    int          cycles = 0;
    int          n_stores = 0;
    int          n_loads = 0;
    int          n_instr;
    int          start;
    int          limit;

    `include "tb_programs.svh"

    cpu_top UUT (
        .clk   (clk),
        .rst   (rst),
        .iaddr (iaddr),
        .idata (idata),
        .raddr (raddr),
        .re    (re),
        .rdata (rdata),
        .waddr (waddr),
        .wdata (wdata),
        .we    (we)
    );

    always #10 clk = ~clk;           // 20 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // memory writes and address capture on the rising edge
    always @(posedge clk) begin
        iaddr_q <= iaddr;
        raddr_q <= raddr;
        re_q    <= re && !rst;
        cycles  <= cycles + 1;
        if (we && !rst) begin
            dmem[waddr[9:0]] <= wdata;
        end
    end

    // read data driven on the falling edge one cycle after the address
    always @(negedge clk) begin
        idata <= imem[iaddr_q[9:0]];
        if (re_q) begin
            rdata <= dmem[raddr_q[9:0]];
        end
    end

    // store checker against the reference sequence
    always @(posedge clk) begin
        if (!rst && we) begin
            if (n_stores >= exp_addr.size()) begin
                abort_run("store seen after the last expected one");
            end else begin
                check("waddr", waddr, exp_addr[n_stores]);
                check("wdata", wdata, exp_data[n_stores]);
                n_stores = n_stores + 1;
            end
        end
    end

    // read strobes against the reference load addresses
    always @(posedge clk) begin
        if (!rst && re) begin
            if (n_loads >= exp_raddr.size()) begin
                abort_run("read strobe seen after the last expected load");
            end else begin
                check("raddr", raddr, exp_raddr[n_loads]);
                n_loads = n_loads + 1;
            end
        end
    end

    initial begin
        void'($urandom(32'h407a8a8b));
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 16'($urandom);
        end
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {5'b11111, 1'b0, 10'(i)};    // no-op padding
        end
        build_program();
        n_instr = iss_run(4096);
        if (n_instr < 0) begin
            abort_run("reference model never reached the final branch");
        end
        repeat (4) begin
            @(negedge clk);
            check("re", 16'(re), 16'd0);
            check("we", 16'(we), 16'd0);
        end
        rst = 1'b0;
        #1;
        check("iaddr", iaddr, 16'd0);                  // first fetch
        check("re", 16'(re), 16'd0);
        check("we", 16'(we), 16'd0);
        start = cycles;
        limit = 3 * n_instr + 50;
        while (n_stores < exp_addr.size()) begin
            @(negedge clk);
            if (cycles - start > limit) begin
                abort_run("timeout before all expected stores appeared");
            end
        end
        repeat (20) @(negedge clk);                    // catch stray stores
        check("n_loads", 16'(n_loads), 16'(exp_raddr.size()));
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
